//--- hw/adma_macros.svh
`ifndef ADMA_MACROS_SVH
`define ADMA_MACROS_SVH

// descriptor word as it comes out of the descriptor FIFO
`define ADMA_DESC_W 64
`define ADMA_ATTR_W 6 // attribute field, low bits of the word

// attribute bit positions
`define ADMA_ATTR_VALID 0
`define ADMA_ATTR_END 1
`define ADMA_ATTR_TRAN 5

// --------------------
// timing
`define ADMA_DES_RD_LATENCY 5 // read strobe to stable FIFO data
`define ADMA_SETTLE_CYCLES 64 // simulation value, about 1M on a real card
`define ADMA_BUSY_RETRIES 10 // settle waits allowed for one block
`define ADMA_WAIT_CNT_W 7 // must hold ADMA_SETTLE_CYCLES-1
`define ADMA_RETRY_CNT_W 4 // must hold ADMA_BUSY_RETRIES-1

`endif

//--- hw/adma_pkg.sv
`default_nettype none

`include "adma_macros.svh"

package adma_pkg;

	// --------------------
	// data widths
	typedef logic [`ADMA_DESC_W-1:0] desc_word_t; // one descriptor entry
	typedef logic [`ADMA_ATTR_W-1:0] desc_attr_t; // valid, end, tran and spare bits

	// --------------------
	// counters
	typedef logic [`ADMA_WAIT_CNT_W-1:0] settle_cnt_t; // settle timer
	typedef logic [`ADMA_RETRY_CNT_W-1:0] retry_cnt_t; // settle waits done for a block

	// sequencer states, walked once per descriptor
	typedef enum logic [2:0] {
		st_idle, // waiting for start
		st_fetch, // request a descriptor
		st_fetch_wait, // descriptor on its way from the FIFO
		st_decode, // look at valid / end / tran
		st_xfer, // kick the data path
		st_xfer_wait, // block in flight
		st_card_wait, // settle time and busy check
		st_cmd12 // stop the multi block write
	} seq_state_t;

endpackage

`default_nettype wire

//--- hw/adma_desc_if.sv
`default_nettype none

// descriptor fetch <-> sequencer
interface adma_desc_if;

	logic fetch_req; // one cycle, from the sequencer
	logic desc_ready; // one cycle, attributes just captured
	logic attr_valid; // held until next capture
	logic attr_end;
	logic attr_tran;

	// fetch side owns the FIFO and the captured attributes
	modport fetch (
		input fetch_req,
		output desc_ready, attr_valid, attr_end, attr_tran
	);

	modport seq (
		output fetch_req,
		input desc_ready, attr_valid, attr_end, attr_tran
	);

endinterface

`default_nettype wire

//--- hw/adma_wait_if.sv
`default_nettype none

// sequencer <-> card wait
interface adma_wait_if;

	logic wait_start; // one cycle, starts a settle wait
	logic last_blk; // qualifies wait_start
	logic wait_done; // one cycle, wait finished
	logic card_free; // qualifies wait_done

	modport seq (output wait_start, last_blk, input wait_done, card_free);

	modport waiter (input wait_start, last_blk, output wait_done, card_free);

endinterface

`default_nettype wire

//--- hw/adma_desc_fetch.sv
`default_nettype none

`include "adma_macros.svh"

// reads one descriptor per fetch_req and hands the attributes to the sequencer
module adma_desc_fetch
	import adma_pkg::*;
(
	input logic clk,
	input logic reset,
	input desc_word_t des_rd_data, // from descriptor FIFO, late by read latency
	adma_desc_if.fetch desc,
	output logic des_fifo_rd_strb // pops one FIFO entry
);

	logic busy; // a read is outstanding
	logic [$clog2(`ADMA_DES_RD_LATENCY+1)-1:0] lat_cnt; // cycles since the read strobe
	logic capture; // FIFO data is stable this cycle
	logic desc_ready_q;
	desc_attr_t attr_q; // attribute field of the last descriptor

	assign capture = busy && (lat_cnt == `ADMA_DES_RD_LATENCY);

	// --------------------
	// read strobe and latency count
	always_ff @(posedge clk) begin
		if (reset) begin
			des_fifo_rd_strb <= 1'b0;
			busy <= 1'b0;
			lat_cnt <= '0;
			desc_ready_q <= 1'b0;
		end else begin
			des_fifo_rd_strb <= desc.fetch_req; // one cycle behind the request
			desc_ready_q <= capture; // ready one cycle after capture
			if (desc.fetch_req) begin
				busy <= 1'b1;
				lat_cnt <= '0; // zero while the strobe is high
			end else if (capture) begin
				busy <= 1'b0; // free for the next request
			end else if (busy) begin
				lat_cnt <= lat_cnt + 1'b1;
			end
		end
	end

	// attribute field sits in the low bits of the word
	always_ff @(posedge clk) begin
		if (capture)
			attr_q <= des_rd_data[`ADMA_ATTR_W-1:0];
	end

	// --------------------
	// to the sequencer
	assign desc.desc_ready = desc_ready_q;
	assign desc.attr_valid = attr_q[`ADMA_ATTR_VALID];
	assign desc.attr_end = attr_q[`ADMA_ATTR_END];
	assign desc.attr_tran = attr_q[`ADMA_ATTR_TRAN];

	// the sequencer must wait for desc_ready before asking again
	a_no_overlap: assert property (
		@(posedge clk) disable iff (reset)
		desc.fetch_req |-> !busy
	) else $error("fetch_req while a descriptor read is outstanding");

endmodule

`default_nettype wire

//--- hw/adma_xfer_seq.sv
`default_nettype none

// ADMA2 write sequencer: walks the descriptor chain, one block per tran entry
module adma_xfer_seq
	import adma_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start_strb, // one cycle, only looked at in idle
	input logic dat_tf_done, // data path finished the block
	adma_desc_if.seq desc,
	adma_wait_if.seq wait_ch,
	output logic blk_start_strb, // one cycle per block
	output logic auto_cmd12_strb, // one cycle at the end of the run
	output logic adma_active // high from start until after CMD12 / stop
);

	seq_state_t state;
	logic wait_start_q; // settle wait request
	logic last_blk_q; // end bit of the block in flight

	// --------------------
	// state machine
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			wait_start_q <= 1'b0;
			last_blk_q <= 1'b0;
		end else begin
			wait_start_q <= 1'b0; // strobe by default
			case (state)
				st_idle: begin
					if (start_strb)
						state <= st_fetch;
				end
				st_fetch: begin
					state <= st_fetch_wait; // fetch_req is out this cycle
				end
				st_fetch_wait: begin
					if (desc.desc_ready) // attributes valid from now on
						state <= st_decode;
				end
				st_decode: begin
					// invalid entry ends the chain quietly
					if (!desc.attr_valid)
						state <= st_idle;
					else if (desc.attr_tran)
						state <= st_xfer;
					else if (!desc.attr_end)
						state <= st_fetch; // nop, take the next one
					else
						state <= st_idle; // end without data, no CMD12
				end
				st_xfer: begin
					state <= st_xfer_wait;
				end
				st_xfer_wait: begin
					if (dat_tf_done) begin
						wait_start_q <= 1'b1;
						last_blk_q <= desc.attr_end;
						state <= st_card_wait;
					end
				end
				st_card_wait: begin
					if (wait_ch.wait_done) begin
						// last block settled, or card stuck busy
						if (last_blk_q || !wait_ch.card_free)
							state <= st_cmd12;
						else
							state <= st_fetch; // card free, next descriptor
					end
				end
				st_cmd12: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle; // recover
				end
			endcase
		end
	end

	// --------------------
	// outputs decoded from state
	assign desc.fetch_req = (state == st_fetch);
	assign blk_start_strb = (state == st_xfer);
	assign auto_cmd12_strb = (state == st_cmd12);
	assign adma_active = (state != st_idle);

	assign wait_ch.wait_start = wait_start_q;
	assign wait_ch.last_blk = last_blk_q; // valid with wait_start

	// state known, and each returning handshake lands in the state that waits for it
	a_state_legal: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(state)
			&& (!desc.desc_ready || state == st_fetch_wait)
			&& (!wait_ch.wait_done || state == st_card_wait)
	) else $error("sequencer state out of step with its handshakes");

endmodule

`default_nettype wire

//--- hw/adma_card_wait.sv
`default_nettype none

`include "adma_macros.svh"

// settle timer after each block, then checks the card busy line
module adma_card_wait
	import adma_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wr_busy, // card holds D0 low while programming
	adma_wait_if.waiter wait_ch
);

	logic running; // a wait is in progress
	logic expired; // settle time is up this cycle
	logic last_q; // no busy check for the last block
	settle_cnt_t timer;
	retry_cnt_t retry_cnt; // settle waits finished for this block
	logic wait_done_q;
	logic card_free_q;

	assign expired = running && (timer == settle_cnt_t'(`ADMA_SETTLE_CYCLES - 1));

	// --------------------
	// timer and retries
	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			timer <= '0;
			retry_cnt <= '0;
			last_q <= 1'b0;
			wait_done_q <= 1'b0;
		end else begin
			wait_done_q <= 1'b0;
			if (wait_ch.wait_start) begin
				running <= 1'b1;
				timer <= '0;
				retry_cnt <= '0; // fresh block
				last_q <= wait_ch.last_blk;
			end else if (expired) begin
				if (last_q || !wr_busy) begin
					running <= 1'b0; // done, card_free set below
					wait_done_q <= 1'b1;
				end else if (retry_cnt < retry_cnt_t'(`ADMA_BUSY_RETRIES - 1)) begin
					retry_cnt <= retry_cnt + 1'b1; // still busy, wait again
					timer <= '0;
				end else begin
					running <= 1'b0; // out of retries
					wait_done_q <= 1'b1;
				end
			end else if (running) begin
				timer <= timer + 1'b1;
			end
		end
	end

	// result sampled with the busy line at expiry
	always_ff @(posedge clk) begin
		if (expired)
			card_free_q <= last_q || !wr_busy;
	end

	assign wait_ch.wait_done = wait_done_q;
	assign wait_ch.card_free = card_free_q;

	// a new wait is only requested after the previous done
	a_done_start: assert property (
		@(posedge clk) disable iff (reset)
		wait_ch.wait_start |-> !wait_ch.wait_done
	) else $error("wait_done and wait_start in the same cycle");

endmodule

`default_nettype wire

//--- hw/adma_top.sv
`default_nettype none

// ADMA2 write engine, plain ports toward host controller and card
module adma_top
	import adma_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start_strb, // begin a run
	input desc_word_t des_rd_data, // descriptor FIFO read data
	input logic dat_tf_done, // block written by the data path
	input logic wr_busy, // card busy on D0
	output logic des_fifo_rd_strb, // pop descriptor FIFO
	output logic blk_start_strb, // send one block
	output logic auto_cmd12_strb, // stop transmission
	output logic adma_active // run in progress
);

	// --------------------
	// internal channels
	adma_desc_if desc_ch ();
	adma_wait_if wait_ch ();

	// input side
	adma_desc_fetch u_fetch (
		.clk (clk),
		.reset (reset),
		.des_rd_data (des_rd_data),
		.desc (desc_ch.fetch),
		.des_fifo_rd_strb (des_fifo_rd_strb)
	);

	// descriptor walk and block order
	adma_xfer_seq u_seq (
		.clk (clk),
		.reset (reset),
		.start_strb (start_strb),
		.dat_tf_done (dat_tf_done),
		.desc (desc_ch.seq),
		.wait_ch (wait_ch.seq),
		.blk_start_strb (blk_start_strb),
		.auto_cmd12_strb (auto_cmd12_strb),
		.adma_active (adma_active)
	);

	// settle and busy check
	adma_card_wait u_wait (
		.clk (clk),
		.reset (reset),
		.wr_busy (wr_busy),
		.wait_ch (wait_ch.waiter)
	);

endmodule

`default_nettype wire

//--- test/adma_tb.sv
`default_nettype none

`include "adma_macros.svh"

// testbench for the ADMA2 write engine, one engine run per table row
module adma_tb
	import adma_pkg::*;
();

	localparam int NUM_ROWS = 10;
	localparam int MAX_DESC = 4; // descriptors per row, unused slots are invalid
	localparam int DP_DELAY = 3; // block strobe to dat_tf_done
	localparam int ROW_BASE = 30; // start, idle gap and stop overhead
	localparam int DESC_BASE = 30; // fetch, decode and data path per descriptor

	logic clk;
	logic reset;
	logic start_strb;
	desc_word_t des_rd_data;
	logic dat_tf_done;
	logic wr_busy;
	logic des_fifo_rd_strb;
	logic blk_start_strb;
	logic auto_cmd12_strb;
	logic adma_active;

	integer seed; // $random state for the upper descriptor bits
	int errors;
	int checks;
	int num_rows; // rows filled so far
	int cycle_limit;
	int cycle_cnt;

	// --------------------
	// scenario table
	string row_name [NUM_ROWS];
	desc_attr_t row_attr [NUM_ROWS][MAX_DESC]; // attribute field per descriptor
	int row_ndesc [NUM_ROWS];
	int row_busy [NUM_ROWS]; // settle waits with the card busy, per block
	int row_reads [NUM_ROWS]; // expected FIFO reads
	int row_blocks [NUM_ROWS]; // expected block strobes
	int row_cmd12 [NUM_ROWS]; // expected CMD12 strobes

	adma_top adma_top_i (
		.clk (clk),
		.reset (reset),
		.start_strb (start_strb),
		.des_rd_data (des_rd_data),
		.dat_tf_done (dat_tf_done),
		.wr_busy (wr_busy),
		.des_fifo_rd_strb (des_fifo_rd_strb),
		.blk_start_strb (blk_start_strb),
		.auto_cmd12_strb (auto_cmd12_strb),
		.adma_active (adma_active)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // period 20
	end

	task automatic add_row(input string name, input int ndesc, input desc_attr_t a0,
		input desc_attr_t a1, input desc_attr_t a2, input desc_attr_t a3, input int busy,
		input int reads, input int blocks, input int cmd12);
		row_name[num_rows] = name;
		row_ndesc[num_rows] = ndesc;
		row_attr[num_rows][0] = a0;
		row_attr[num_rows][1] = a1;
		row_attr[num_rows][2] = a2;
		row_attr[num_rows][3] = a3;
		row_busy[num_rows] = busy;
		row_reads[num_rows] = reads;
		row_blocks[num_rows] = blocks;
		row_cmd12[num_rows] = cmd12;
		num_rows++;
	endtask

	// attr: 0x20 tran only, 0x21 tran, 0x23 tran+end, 0x01 nop, 0x03 end only
	task automatic fill_table();
		add_row("invalid_first", 1, 6'h20, 6'h00, 6'h00, 6'h00, 0, 1, 0, 0);
		add_row("single_last", 1, 6'h23, 6'h00, 6'h00, 6'h00, 0, 1, 1, 1);
		add_row("chain_three", 3, 6'h21, 6'h21, 6'h23, 6'h00, 0, 3, 3, 1);
		add_row("nop_then_xfer", 3, 6'h01, 6'h21, 6'h23, 6'h00, 0, 3, 2, 1);
		add_row("end_no_tran", 3, 6'h21, 6'h01, 6'h03, 6'h00, 0, 3, 1, 0);
		add_row("spare_bits", 2, 6'h3d, 6'h1f, 6'h00, 6'h00, 0, 2, 1, 0); // spare bits ignored
		add_row("busy_three", 3, 6'h21, 6'h21, 6'h23, 6'h00, 3, 3, 3, 1);
		add_row("busy_below_limit", 2, 6'h21, 6'h23, 6'h00, 6'h00,
			`ADMA_BUSY_RETRIES - 1, 2, 2, 1);
		add_row("busy_limit", 3, 6'h21, 6'h21, 6'h23, 6'h00, `ADMA_BUSY_RETRIES, 1, 1, 1);
		add_row("busy_last_ignored", 1, 6'h23, 6'h00, 6'h00, 6'h00, `ADMA_BUSY_RETRIES, 1, 1, 1);
	endtask

	task automatic check_value(input string test, input string what, input int expected,
		input int actual);
		checks++;
		assert (actual == expected)
		else begin
			errors++;
			$display("FAILED %s: %s expected %0d, actual %0d", test, what, expected, actual);
		end
	endtask

	// --------------------
	// one engine run with FIFO, data path and card models
	task automatic run_row(input int r);
		int run_cyc;
		int reads;
		int blocks;
		int cmd12s;
		int dp_delay;
		int busy_left; // cycles the card still holds busy
		int last_done; // cycle of the last dat_tf_done
		bit seen_active;
		bit finished;
		reads = 0;
		blocks = 0;
		cmd12s = 0;
		dp_delay = 0;
		busy_left = 0;
		last_done = 0;
		seen_active = 1'b0;
		finished = 1'b0;
		run_cyc = 0;
		@(negedge clk);
		start_strb = 1'b1;
		dat_tf_done = 1'b0;
		wr_busy = 1'b0;
		while (!finished) begin
			@(negedge clk);
			run_cyc++;
			start_strb = (run_cyc == 6); // stray start while active, must be ignored
			dat_tf_done = 1'b0;
			if (des_fifo_rd_strb) begin // FIFO pops the next entry and holds it
				if (reads == 0)
					check_value(row_name[r], "first read delay", 2, run_cyc);
				des_rd_data = {$random(seed), $random(seed)};
				des_rd_data[`ADMA_ATTR_W-1:0] = (reads < MAX_DESC) ? row_attr[r][reads] : '0;
				reads++;
			end
			if (blk_start_strb) begin
				blocks++;
				dp_delay = DP_DELAY;
			end else if (dp_delay > 0) begin
				dp_delay--;
				if (dp_delay == 0) begin // block written, card starts programming
					dat_tf_done = 1'b1;
					last_done = run_cyc;
					if (row_busy[r] > 0)
						busy_left = row_busy[r] * `ADMA_SETTLE_CYCLES + `ADMA_SETTLE_CYCLES / 2;
				end
			end
			if (auto_cmd12_strb) begin
				cmd12s++;
				checks++;
				assert (run_cyc - last_done >= `ADMA_SETTLE_CYCLES)
				else begin
					errors++;
					$display("FAILED %s: cmd12 delay expected >= %0d, actual %0d",
						row_name[r], `ADMA_SETTLE_CYCLES, run_cyc - last_done);
				end
			end
			wr_busy = (busy_left > 0); // busy across whole settle waits
			if (busy_left > 0)
				busy_left--;
			if (adma_active)
				seen_active = 1'b1;
			else if (seen_active)
				finished = 1'b1; // run over once active falls
		end
		check_value(row_name[r], "FIFO reads", row_reads[r], reads);
		check_value(row_name[r], "block strobes", row_blocks[r], blocks);
		check_value(row_name[r], "CMD12 strobes", row_cmd12[r], cmd12s);
	endtask

	task automatic idle_gap(input string test, input int n);
		int i;
		for (i = 0; i < n; i++) begin
			@(negedge clk);
			check_value(test, "outputs while idle", 0,
				int'({des_fifo_rd_strb, blk_start_strb, auto_cmd12_strb, adma_active}));
		end
	endtask

	// --------------------
	// main sequence
	initial begin : main
		int r;
		seed = 32'hc80b_d6df;
		reset = 1'b1;
		start_strb = 1'b0;
		des_rd_data = '0;
		dat_tf_done = 1'b0;
		wr_busy = 1'b0;
		errors = 0;
		checks = 0;
		num_rows = 0;
		fill_table();
		cycle_limit = 40;
		for (r = 0; r < num_rows; r++) // worst case every block uses all retries
			cycle_limit += ROW_BASE
				+ row_ndesc[r] * (DESC_BASE + `ADMA_BUSY_RETRIES * (`ADMA_SETTLE_CYCLES + 2));
		repeat (16) @(negedge clk);
		reset = 1'b0;
		idle_gap("reset", 2); // all outputs low after reset
		for (r = 0; r < num_rows; r++) begin
			run_row(r);
			idle_gap(row_name[r], 3);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// watchdog, counts from the end of reset
	initial begin : watchdog
		cycle_cnt = 0;
		@(negedge reset);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("engine did not finish within %0d cycles", cycle_limit);
		$display("checks: %0d, errors: %0d", checks, errors + 1);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/adma_pkg.sv
hw/adma_desc_if.sv
hw/adma_wait_if.sv
hw/adma_desc_fetch.sv
hw/adma_xfer_seq.sv
hw/adma_card_wait.sv
hw/adma_top.sv
test/adma_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ADMA2 write engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module adma_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vadma_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
